// ==== bench/tb_cfg_fabric.sv ====
// Configuration fabric testbench
`timescale 1ns/100ps
`default_nettype none

module tb_cfg_fabric;

  // ----------------------------------------------------------------------
  // Run length and clocking
  // ----------------------------------------------------------------------
  localparam int clk_period    = 8;    // ns
  localparam int reset_cycles  = 5;
  localparam int n_directed    = 120;  // Upper bound for all directed phases
  localparam int n_rand_cycles = 300;  // Mixed write, read, preset traffic
  localparam int n_lut_cycles  = 200;  // Dense writes with LUT evaluation
  localparam int n_test_cycles = n_directed + n_rand_cycles + n_lut_cycles;

  // ----------------------------------------------------------------------
  // DUT signals
  // ----------------------------------------------------------------------
  logic                          clk = 1'b0;
  logic                          rst;
  logic                          cfg_we;
  cfg_pkg::cfg_wr_t              cfg_wr;
  logic                          cfg_preset;
  logic                          rd_en;
  logic [cfg_pkg::addr_w-1:0]    rd_addr;
  logic [cfg_pkg::word_w-1:0]    rd_data;
  logic                          rd_valid;
  cfg_pkg::lut_in_t              lut_in;
  logic [cfg_pkg::num_words-1:0] lut_out;

  // Shadow model state
  logic [cfg_pkg::num_words-1:0][cfg_pkg::word_w-1:0] shadow;  // Cell contents now
  logic                          pend_we;      // Write waiting in the decoder stage
  logic                          pend_preset;  // Preset waiting in the decoder stage
  cfg_pkg::cfg_wr_t              pend_wr;
  logic                          exp_rd_valid;
  logic [cfg_pkg::word_w-1:0]    exp_rd_data;
  logic [cfg_pkg::num_words-1:0] exp_lut_out;
  logic [31:0]                   rng_state;    // xorshift state

  always #(clk_period / 2) clk = ~clk;

  cfg_fabric_top u_cfg_fabric_top (
    .clk        (clk),
    .rst        (rst),
    .cfg_we     (cfg_we),
    .cfg_wr     (cfg_wr),
    .cfg_preset (cfg_preset),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .rd_valid   (rd_valid),
    .lut_in     (lut_in),
    .lut_out    (lut_out)
  );

  // ----------------------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------------------
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic cfg_pkg::lut_in_t rand_lut_in();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_rand();
    lo = next_rand();
    return {hi, lo};  // Sixteen 4-bit lanes
  endfunction

  function automatic cfg_pkg::cfg_wr_t make_wr(input logic [cfg_pkg::addr_w-1:0] addr,
                                               input logic [cfg_pkg::word_w-1:0] data);
    cfg_pkg::cfg_wr_t w;
    w.addr = addr;
    w.data = data;
    return w;
  endfunction

  // ----------------------------------------------------------------------
  // Model and checks
  // ----------------------------------------------------------------------
  // Called just after a rising edge, inputs still hold what that edge sampled
  task automatic model_edge();
    for (int i = 0; i < cfg_pkg::num_words; i++) begin
      exp_lut_out[i] = shadow[i][lut_in[i]];  // Frames as they were before the edge
    end
    exp_rd_valid = rd_en;
    if (rd_en) begin
      exp_rd_data = shadow[rd_addr];  // Write landing on this edge not seen
    end
    // Decoder stage from the previous edge reaches the cells now
    if (pend_preset) begin
      shadow = '1;
    end else if (pend_we) begin
      shadow[pend_wr.addr] = pend_wr.data;
    end
    pend_preset = cfg_preset;
    pend_we     = cfg_we & ~cfg_preset;  // Preset drops a same-cycle write
    pend_wr     = cfg_wr;
  endtask

  task automatic value_error(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    $display("ERR %s expected %h actual %h at %0t ns", name, exp, act, $time);
    $display("TEST FAIL");
    $fatal(1, "Output mismatch");
  endtask

  task automatic check_outputs();
    assert (rd_valid === exp_rd_valid) else
      value_error("rd_valid", 32'(exp_rd_valid), 32'(rd_valid));
    if (exp_rd_valid) begin  // rd_data is only defined with the valid pulse
      assert (rd_data === exp_rd_data) else
        value_error("rd_data", 32'(exp_rd_data), 32'(rd_data));
    end
    assert (lut_out === exp_lut_out) else
      value_error("lut_out", 32'(exp_lut_out), 32'(lut_out));
  endtask

  // Drives one cycle of inputs, waits for the edge, then checks the results
  task automatic run_cycle(input logic we, input cfg_pkg::cfg_wr_t wr, input logic preset,
                           input logic rd, input logic [cfg_pkg::addr_w-1:0] addr,
                           input cfg_pkg::lut_in_t lin);
    cfg_we     = we;
    cfg_wr     = wr;
    cfg_preset = preset;
    rd_en      = rd;
    rd_addr    = addr;
    lut_in     = lin;
    @(posedge clk);
    model_edge();
    #1;  // Outputs settled, next inputs go out here too
    check_outputs();
  endtask

  task automatic idle_cycle();
    run_cycle(1'b0, '0, 1'b0, 1'b0, '0, rand_lut_in());
  endtask

  task automatic read_all_frames();
    for (int i = 0; i < cfg_pkg::num_words; i++) begin
      run_cycle(1'b0, '0, 1'b0, 1'b1, i[cfg_pkg::addr_w-1:0], rand_lut_in());
    end
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    logic [31:0]                r;
    logic [cfg_pkg::addr_w-1:0] a;
    logic [cfg_pkg::word_w-1:0] d;

    rng_state    = 32'h69135294;
    rst          = 1'b1;
    cfg_we       = 1'b0;
    cfg_wr       = '0;
    cfg_preset   = 1'b0;
    rd_en        = 1'b0;
    rd_addr      = '0;
    lut_in       = '0;
    shadow       = '0;  // Cells clear on reset
    pend_we      = 1'b0;
    pend_preset  = 1'b0;
    pend_wr      = '0;
    exp_rd_valid = 1'b0;
    exp_rd_data  = '0;
    exp_lut_out  = '0;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst = 1'b0;

    // All frames zero after reset, LUTs give 0 for any input
    read_all_frames();

    // Read right after a write sees old data, one cycle later the new
    r = next_rand();
    a = r[3:0];
    d = r[31:16];
    run_cycle(1'b1, make_wr(a, d), 1'b0, 1'b0, '0, rand_lut_in());
    run_cycle(1'b0, '0, 1'b0, 1'b1, a, rand_lut_in());  // Old contents
    run_cycle(1'b0, '0, 1'b0, 1'b1, a, rand_lut_in());  // New contents

    // Random mix, presets kept rare
    for (int n = 0; n < n_rand_cycles; n++) begin
      r = next_rand();
      run_cycle(r[0], make_wr(r[11:8], r[31:16]), (r[7:2] == 6'd0), r[1], r[15:12],
                rand_lut_in());
    end

    // Back to back writes on one frame, then a neighbour
    r = next_rand();
    a = r[3:0];
    run_cycle(1'b1, make_wr(a, r[31:16]), 1'b0, 1'b0, '0, rand_lut_in());
    r = next_rand();
    run_cycle(1'b1, make_wr(a, r[15:0]), 1'b0, 1'b0, '0, rand_lut_in());
    r = next_rand();
    run_cycle(1'b1, make_wr(a + cfg_pkg::addr_w'(1), r[15:0]), 1'b0, 1'b0, '0,
              rand_lut_in());
    idle_cycle();  // Neighbour write reaches the cells
    run_cycle(1'b0, '0, 1'b0, 1'b1, a, rand_lut_in());  // Last data of a
    idle_cycle();

    // Preset fills every frame with ones
    run_cycle(1'b0, '0, 1'b1, 1'b0, '0, rand_lut_in());
    idle_cycle();
    read_all_frames();

    // Preset together with a write drops the write
    r = next_rand();
    a = r[3:0];
    run_cycle(1'b1, make_wr(a, r[31:16] & 16'h7ffe), 1'b0, 1'b0, '0, rand_lut_in());
    idle_cycle();
    run_cycle(1'b0, '0, 1'b0, 1'b1, a, rand_lut_in());  // Written value
    run_cycle(1'b1, make_wr(a, 16'h0000), 1'b1, 1'b0, '0, rand_lut_in());
    idle_cycle();
    read_all_frames();

    // Dense random frames against random LUT inputs
    for (int n = 0; n < n_lut_cycles; n++) begin
      r = next_rand();
      run_cycle(r[0] | r[1], make_wr(r[11:8], r[31:16]), 1'b0, r[2], r[15:12],
                rand_lut_in());
    end
    idle_cycle();

    $display("TEST PASS");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Watchdog
  // ----------------------------------------------------------------------
  initial begin
    #((reset_cycles + n_test_cycles + 20) * clk_period);
    $display("Watchdog expired before the test sequence finished");
    $display("TEST FAIL");
    $fatal(1, "Timeout");
  end

endmodule : tb_cfg_fabric

`default_nettype wire

// ==== filelist.f ====
source/cfg_pkg.sv
source/cfg_wl_decoder.sv
source/cfg_array.sv
source/lut_bank.sv
source/cfg_fabric_top.sv
bench/tb_cfg_fabric.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the configuration fabric testbench with Verilator.
# The exit status is non-zero when the build fails or the simulation
# ends in $fatal.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
  --top-module tb_cfg_fabric -f filelist.f -o tb_cfg_fabric &&
./obj_dir/tb_cfg_fabric ||
{ echo "Build or simulation failed" >&2; exit 1; }

// ==== source/cfg_array.sv ====
// Programmable configuration cell array
`timescale 1ns/100ps
`default_nettype none

module cfg_array (
  input  logic                                             clk,
  input  logic                                             rst,
  input  cfg_pkg::cfg_lines_t                              lines,     // From decoder
  input  logic                                             rd_en,     // Readback strobe
  input  logic [cfg_pkg::addr_w-1:0]                       rd_addr,   // Frame to read
  output logic [cfg_pkg::word_w-1:0]                       rd_data,   // Frame contents
  output logic                                             rd_valid,  // One cycle after rd_en
  output logic [cfg_pkg::num_words-1:0][cfg_pkg::word_w-1:0] frames   // Whole array
);

  // ----------------------------------------------------------------------
  // Cell matrix
  // ----------------------------------------------------------------------
  // Row w is selected by lines.wl[w], column b listens to lines.bl[b].
  // Each cell is a clocked version of a write-enabled bit with set and
  // reset: clear dominates, then set, then the word line write.
  for (genvar w = 0; w < cfg_pkg::num_words; w++) begin : g_row
    for (genvar b = 0; b < cfg_pkg::word_w; b++) begin : g_col
      logic cell_q;  // Stored configuration bit

      always_ff @(posedge clk) begin
        if (rst) begin
          cell_q <= 1'b0;           // Reset variant, cell goes to 0
        end else if (lines.preset) begin
          cell_q <= 1'b1;           // Set variant, cell goes to 1
        end else if (lines.wl[w]) begin
          cell_q <= lines.bl[b];    // bl = 1 stores 1, bl = 0 stores 0
        end
        // Word line low, cell keeps its bit
      end

      assign frames[w][b] = cell_q;  // Cell output onto the frame bus
    end
  end

  // ----------------------------------------------------------------------
  // Readback port
  // ----------------------------------------------------------------------
  // Samples the frame as it is before the edge, so a write landing on
  // the same edge is not yet visible
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= frames[rd_addr];  // Registered frame select
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_en;  // Fixed one cycle read latency
    end
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  // Valid pulse tracks the strobe by one cycle, never more or less
  property p_rd_valid;
    @(posedge clk) disable iff (rst)
      !$past(rst) |-> (rd_valid == $past(rd_en));
  endproperty
  a_rd_valid : assert property (p_rd_valid);

  // A preset line fills every frame with ones on the following edge
  property p_preset_fill;
    @(posedge clk) disable iff (rst)
      lines.preset |=> (frames == '1);
  endproperty
  a_preset_fill : assert property (p_preset_fill);

  // Frames only change through preset or an active word line
  property p_frames_stable;
    @(posedge clk) disable iff (rst)
      (!lines.preset && !(|lines.wl)) |=> $stable(frames);
  endproperty
  a_frames_stable : assert property (p_frames_stable);

endmodule : cfg_array

`default_nettype wire

// ==== source/cfg_fabric_top.sv ====
// Programmable tile configuration top
`timescale 1ns/100ps
`default_nettype none

module cfg_fabric_top (
  input  logic                          clk,
  input  logic                          rst,
  // Configuration port
  input  logic                          cfg_we,      // Frame write strobe
  input  cfg_pkg::cfg_wr_t              cfg_wr,      // Address and data
  input  logic                          cfg_preset,  // Set all cells
  // Readback port
  input  logic                          rd_en,
  input  logic [cfg_pkg::addr_w-1:0]    rd_addr,
  output logic [cfg_pkg::word_w-1:0]    rd_data,
  output logic                          rd_valid,
  // User logic
  input  cfg_pkg::lut_in_t              lut_in,
  output logic [cfg_pkg::num_words-1:0] lut_out
);

  // ----------------------------------------------------------------------
  // Internal buses
  // ----------------------------------------------------------------------
  cfg_pkg::cfg_lines_t                                lines;   // Decoder to array
  logic [cfg_pkg::num_words-1:0][cfg_pkg::word_w-1:0] frames;  // Array to LUTs

  // Input side, strobes to programming lines
  cfg_wl_decoder u_decoder (
    .clk        (clk),
    .rst        (rst),
    .cfg_we     (cfg_we),
    .cfg_wr     (cfg_wr),
    .cfg_preset (cfg_preset),
    .lines      (lines)
  );

  // Storage and readback
  cfg_array u_array (
    .clk      (clk),
    .rst      (rst),
    .lines    (lines),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .rd_valid (rd_valid),
    .frames   (frames)
  );

  // Output side, LUTs evaluated from stored frames
  lut_bank u_lut (
    .clk     (clk),
    .rst     (rst),
    .frames  (frames),
    .lut_in  (lut_in),
    .lut_out (lut_out)
  );

endmodule : cfg_fabric_top

`default_nettype wire

// ==== source/cfg_pkg.sv ====
// Configuration memory shared definitions
`default_nettype none

package cfg_pkg;

  // ----------------------------------------------------------------------
  // Array geometry
  // ----------------------------------------------------------------------
  localparam int num_words = 16;  // Frames in the array, one per LUT
  localparam int word_w    = 16;  // Bits per frame, one 4-input truth table
  localparam int addr_w    = 4;   // Frame address, log2 of num_words
  localparam int lut_k     = 4;   // LUT inputs, log2 of word_w

  // ----------------------------------------------------------------------
  // Configuration path types
  // ----------------------------------------------------------------------

  // One frame write as seen on the configuration port
  typedef struct packed {
    logic [addr_w-1:0] addr;  // Target frame
    logic [word_w-1:0] data;  // Truth table bits, bit n is output for input n
  } cfg_wr_t;

  // Programming lines from the decoder into the cell array
  typedef struct packed {
    logic [num_words-1:0] wl;      // Word lines, zero or one-hot
    logic [word_w-1:0]    bl;      // Bit lines, shared by every row
    logic                 preset;  // Global set, loads 1 into all cells
  } cfg_lines_t;

  // User inputs, lane i drives the select of LUT i
  typedef logic [num_words-1:0][lut_k-1:0] lut_in_t;

endpackage : cfg_pkg

`default_nettype wire

// ==== source/cfg_wl_decoder.sv ====
// Word line and bit line decoder
`timescale 1ns/100ps
`default_nettype none

module cfg_wl_decoder (
  input  logic                clk,
  input  logic                rst,
  input  logic                cfg_we,      // Frame write strobe
  input  cfg_pkg::cfg_wr_t    cfg_wr,      // Address and data, valid with cfg_we
  input  logic                cfg_preset,  // Global set strobe
  output cfg_pkg::cfg_lines_t lines        // Registered programming lines
);

  // ----------------------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------------------
  logic [cfg_pkg::num_words-1:0] wl_next;  // One-hot of cfg_wr.addr
  logic                          wr_go;    // Write survives preset

  // Preset wins over a write in the same cycle
  assign wr_go = cfg_we & ~cfg_preset;

  always_comb begin
    wl_next = '0;
    if (wr_go) begin
      wl_next[cfg_wr.addr] = 1'b1;  // Raise the addressed row only
    end
  end

  // ----------------------------------------------------------------------
  // Line registers
  // ----------------------------------------------------------------------
  // Word lines live for exactly one cycle per accepted write, so the
  // array sees a clean single-edge programming pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      lines <= '0;  // No row selected, no preset
    end else begin
      lines.wl     <= wl_next;
      lines.preset <= cfg_preset;
      if (wr_go) begin
        lines.bl <= cfg_wr.data;  // Hold bit lines between writes
      end
    end
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  // At most one row is programmed per edge
  property p_wl_onehot0;
    @(posedge clk) disable iff (rst)
      $onehot0(lines.wl);
  endproperty
  a_wl_onehot0 : assert property (p_wl_onehot0);

  // A word line pulse always traces back to a write without preset
  property p_wl_from_write;
    @(posedge clk) disable iff (rst)
      (|lines.wl) |-> ($past(cfg_we) && !$past(cfg_preset) && !lines.preset);
  endproperty
  a_wl_from_write : assert property (p_wl_from_write);

endmodule : cfg_wl_decoder

`default_nettype wire

// ==== source/lut_bank.sv ====
// Bank of 4-input lookup tables
`timescale 1ns/100ps
`default_nettype none

module lut_bank (
  input  logic                                               clk,
  input  logic                                               rst,
  input  logic [cfg_pkg::num_words-1:0][cfg_pkg::word_w-1:0] frames,  // Truth tables
  input  cfg_pkg::lut_in_t                                   lut_in,  // Select lanes
  output logic [cfg_pkg::num_words-1:0]                      lut_out  // Registered results
);

  // ----------------------------------------------------------------------
  // Table lookup
  // ----------------------------------------------------------------------
  // LUT i uses frame i as its truth table. The 4-bit lane picks one of
  // the 16 stored bits, so input pattern n returns frame bit n.
  logic [cfg_pkg::num_words-1:0] lut_sel;  // Combinational LUT results

  always_comb begin
    lut_sel = '0;
    for (int i = 0; i < cfg_pkg::num_words; i++) begin
      lut_sel[i] = frames[i][lut_in[i]];  // Mux on the truth table bits
    end
  end

  // ----------------------------------------------------------------------
  // Output stage
  // ----------------------------------------------------------------------
  // One cycle latency, inputs and frames sampled at the same edge
  always_ff @(posedge clk) begin
    if (rst) begin
      lut_out <= '0;
    end else begin
      lut_out <= lut_sel;
    end
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  // A constant frame forces its LUT output regardless of the lane
  for (genvar i = 0; i < cfg_pkg::num_words; i++) begin : g_chk
    property p_const_one;
      @(posedge clk) disable iff (rst)
        (frames[i] == '1) |=> lut_out[i];
    endproperty
    a_const_one : assert property (p_const_one);

    property p_const_zero;
      @(posedge clk) disable iff (rst)
        (frames[i] == '0) |=> !lut_out[i];
    endproperty
    a_const_zero : assert property (p_const_zero);
  end

endmodule : lut_bank

`default_nettype wire
